//--- verilog.f
+incdir+include
source/system_pkg.sv
source/bus_split.sv
source/int_mem.sv
source/boot_ctrl.sv
source/uart_core.sv
source/system.sv
sim/system_props.sv
sim/system_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= system_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Some tests failed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/system_tb.sv
`default_nettype none

`include "system_defs.svh"

module system_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import system_pkg::*;

   localparam int TIMEOUT = 50;
   localparam int HALF    = (1 << `MEM_ADDR_W) / 2;

   logic        clk;
   logic        rst_n;
   bus_req_t    ibus_req;
   bus_resp_t   ibus_resp;
   bus_req_t    dbus_req;
   bus_resp_t   dbus_resp;
   logic        cpu_reset;
   logic        uart_txd;
   logic        uart_rxd;
   logic        uart_rts;
   logic        uart_cts;

   int          errors;
   int          timeouts;
   logic [31:0] lcg_state;
   logic [31:0] model [1 << `MEM_ADDR_W];
   int          words [32];

   system UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .ibus_req  (ibus_req),
      .ibus_resp (ibus_resp),
      .dbus_req  (dbus_req),
      .dbus_resp (dbus_resp),
      .cpu_reset (cpu_reset),
      .uart_txd  (uart_txd),
      .uart_rxd  (uart_rxd),
      .uart_rts  (uart_rts),
      .uart_cts  (uart_cts)
   );

   // serial loopback
   assign uart_rxd = uart_txd;

   always #4 clk = ~clk;

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // bytes with strobe set come from the new word
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
      logic [31:0] result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   ////////////////////
   // bus masters
   ////////////////////

   task automatic data_access(input logic [15:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata);
      int waited;
      waited = 0;
      @(negedge clk);
      dbus_req.valid = 1'b1;
      dbus_req.addr  = addr;
      dbus_req.wdata = wdata;
      dbus_req.wstrb = strb;
      do begin
         @(negedge clk);
         waited++;
      end while (!dbus_resp.ready && waited < TIMEOUT);
      if (!dbus_resp.ready) begin
         $display("timeout: no ready on the data bus for address %h", addr);
         timeouts++;
      end
      rdata          = dbus_resp.rdata;
      dbus_req.valid = 1'b0;
      dbus_req.wstrb = 4'h0;
   endtask

   task automatic fetch_word(input logic [15:0] addr, output logic [31:0] rdata);
      int waited;
      waited = 0;
      @(negedge clk);
      ibus_req.valid = 1'b1;
      ibus_req.addr  = addr;
      do begin
         @(negedge clk);
         waited++;
      end while (!ibus_resp.ready && waited < TIMEOUT);
      if (!ibus_resp.ready) begin
         $display("timeout: no ready on the instruction bus for address %h", addr);
         timeouts++;
      end
      rdata          = ibus_resp.rdata;
      ibus_req.valid = 1'b0;
   endtask

   ////////////////////
   // test sequence
   ////////////////////

   initial begin
      logic [31:0] rd;
      logic [31:0] r;
      logic [7:0]  tx_byte;
      int          idx;
      int          waited;
      int          pulse;

      errors    = 0;
      timeouts  = 0;
      lcg_state = 32'hfe41;
      clk       = 1'b0;
      rst_n     = 1'b0;
      ibus_req  = '0;
      dbus_req  = '0;
      uart_cts  = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // state out of reset, before any edge can change it
      check_value("ibus ready after reset", 32'd0, 32'(ibus_resp.ready));
      check_value("dbus ready after reset", 32'd0, 32'(dbus_resp.ready));
      check_value("cpu_reset after reset", 32'd0, 32'(cpu_reset));
      check_value("uart_txd after reset", 32'd1, 32'(uart_txd));
      check_value("uart_rts after reset", 32'd0, 32'(uart_rts));
      data_access(16'hc000, 32'd0, 4'h0, rd);
      check_value("boot flag after reset", 32'd1, rd);

      // lower words and their boot images in the upper half
      for (int i = 0; i < 16; i++) begin
         words[i]      = i;
         words[i + 16] = HALF + i;
      end
      foreach (words[i]) begin
         model[words[i]] = next_random();
         data_access(16'(words[i] * 4), model[words[i]], 4'hf, rd);
      end
      for (int n = 0; n < 40; n++) begin
         r   = next_random();
         idx = words[r[4:0]];
         if (r[11:8] == 4'h0) begin
            r[8] = 1'b1;
         end
         rd         = next_random();
         model[idx] = merge_bytes(model[idx], rd, r[11:8]);
         data_access(16'(idx * 4), rd, r[11:8], rd);
      end
      foreach (words[i]) begin
         data_access(16'(words[i] * 4), 32'd0, 4'h0, rd);
         check_value($sformatf("mem word %0d", words[i]), model[words[i]], rd);
      end

      // boot fetches map to the upper half
      for (int k = 0; k < 16; k++) begin
         fetch_word(16'(k * 4), rd);
         check_value($sformatf("boot fetch %0d", k), model[k + HALF], rd);
      end

      // clearing boot restarts the cpu
      data_access(16'hc000, 32'd0, 4'hf, rd);
      waited = 0;
      while (!cpu_reset && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!cpu_reset) begin
         $display("timeout: cpu_reset never rose after clearing boot");
         timeouts++;
      end
      pulse = 0;
      while (cpu_reset && pulse < TIMEOUT) begin
         pulse++;
         @(negedge clk);
      end
      check_value("cpu_reset pulse length", `BOOT_RESET_CYCLES, 32'(pulse));
      data_access(16'hc000, 32'd0, 4'h0, rd);
      check_value("boot flag after clear", 32'd0, rd);
      for (int k = 0; k < 16; k++) begin
         fetch_word(16'(k * 4), rd);
         check_value($sformatf("run fetch %0d", k), model[k], rd);
      end

      // uart byte through the loopback
      r       = next_random();
      tx_byte = r[7:0];
      data_access(16'h8004, {24'd0, tx_byte}, 4'h1, rd);
      data_access(16'h8000, 32'd0, 4'h0, rd);
      check_value("uart status while sending", 32'd1, rd);
      waited = 0;
      do begin
         data_access(16'h8000, 32'd0, 4'h0, rd);
         waited++;
      end while (!rd[1] && waited < 200);
      if (!rd[1]) begin
         $display("timeout: uart byte never arrived through the loopback");
         timeouts++;
      end
      check_value("uart rts with byte held", 32'd1, 32'(uart_rts));
      data_access(16'h8008, 32'd0, 4'h0, rd);
      check_value("uart rx byte", {24'd0, tx_byte}, rd);
      data_access(16'h8000, 32'd0, 4'h0, rd);
      check_value("uart rx_valid after read", 32'd0, {31'd0, rd[1]});
      check_value("uart rts after read", 32'd0, 32'(uart_rts));

      repeat (2) @(negedge clk);
      $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
               errors, timeouts, UUT.props.fail_count);
      if (errors == 0 && timeouts == 0 && UUT.props.fail_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/system_props.sv
`default_nettype none

`include "system_defs.svh"

module system_props (
   input logic                  clk,
   input logic                  rst_n,
   input system_pkg::bus_req_t  ibus_req,
   input system_pkg::bus_resp_t ibus_resp,
   input system_pkg::bus_req_t  dbus_req,
   input system_pkg::bus_resp_t dbus_resp,
   input logic                  boot,
   input logic                  cpu_reset,
   input logic                  uart_txd,
   input logic                  uart_rts
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;
   int unsigned pulse_len;

   // cycles that cpu_reset has been high so far
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pulse_len <= 0;
      end else if (cpu_reset) begin
         pulse_len <= pulse_len + 1;
      end else begin
         pulse_len <= 0;
      end
   end

   ////////////////////
   // bus handshake
   ////////////////////

   ibus_ready_follows: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_req.valid && !ibus_resp.ready |=> ibus_resp.ready)
      else begin
         fail_count++;
         $error("instruction bus ready did not follow valid");
      end

   ibus_ready_accepted: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_resp.ready |-> $past(ibus_req.valid))
      else begin
         fail_count++;
         $error("instruction bus ready without a valid request");
      end

   dbus_ready_follows: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_req.valid && !dbus_resp.ready |=> dbus_resp.ready)
      else begin
         fail_count++;
         $error("data bus ready did not follow valid");
      end

   dbus_ready_accepted: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_resp.ready |-> $past(dbus_req.valid))
      else begin
         fail_count++;
         $error("data bus ready without a valid request");
      end

   ////////////////////
   // boot and cpu reset
   ////////////////////

   // pulse starts the cycle after the clearing write is answered
   reset_after_clear: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(boot) |=> cpu_reset)
      else begin
         fail_count++;
         $error("cpu reset did not start after boot was cleared");
      end

   reset_pulse_len: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(cpu_reset) |-> pulse_len == `BOOT_RESET_CYCLES)
      else begin
         fail_count++;
         $error("cpu reset pulse has the wrong length");
      end

   reset_pulse_bound: assert property (@(posedge clk) disable iff (!rst_n)
      cpu_reset |-> pulse_len < `BOOT_RESET_CYCLES)
      else begin
         fail_count++;
         $error("cpu reset pulse runs too long");
      end

   ////////////////////
   // state out of reset
   ////////////////////

   txd_idle: assert property (@(posedge clk) $rose(rst_n) |-> uart_txd)
      else begin
         fail_count++;
         $error("uart txd not idle high after reset");
      end

   reset_values: assert property (@(posedge clk)
      $rose(rst_n) |-> boot && !cpu_reset && !uart_rts)
      else begin
         fail_count++;
         $error("boot, cpu reset or rts wrong after reset");
      end

endmodule

bind system system_props props (
   .clk       (clk),
   .rst_n     (rst_n),
   .ibus_req  (ibus_req),
   .ibus_resp (ibus_resp),
   .dbus_req  (dbus_req),
   .dbus_resp (dbus_resp),
   .boot      (boot),
   .cpu_reset (cpu_reset),
   .uart_txd  (uart_txd),
   .uart_rts  (uart_rts)
);

`default_nettype wire

//--- source/system.sv
`default_nettype none

`include "system_defs.svh"

module system (
   input  logic                  clk,
   input  logic                  rst_n,
   input  system_pkg::bus_req_t  ibus_req,
   output system_pkg::bus_resp_t ibus_resp,
   input  system_pkg::bus_req_t  dbus_req,
   output system_pkg::bus_resp_t dbus_resp,
   output logic                  cpu_reset,
   output logic                  uart_txd,
   input  logic                  uart_rxd,
   output logic                  uart_rts,
   input  logic                  uart_cts
);

   import system_pkg::*;

   localparam int N_REGIONS = 1 << `REGION_W;

   // region ownership bitmaps for the splits
   localparam logic [N_REGIONS-1:0] MEM_MASK  = N_REGIONS'(1) << `REGION_MEM;
   localparam logic [N_REGIONS-1:0] UART_MASK = N_REGIONS'(1) << `REGION_UART;
   localparam logic [N_REGIONS-1:0] BOOT_MASK = N_REGIONS'(1) << `REGION_BOOT;

   // data bus slaves, 0 is memory and 1 the peripheral bus
   bus_req_t  dbus_s_req  [2];
   bus_resp_t dbus_s_resp [2];

   // peripheral bus slaves, 0 is uart and 1 boot control
   bus_req_t  pbus_s_req  [2];
   bus_resp_t pbus_s_resp [2];

   logic      boot;

   ////////////////////
   // bus fabric
   ////////////////////

   bus_split #(
      .N_SLAVES    (2),
      .REGION_MASK ({UART_MASK | BOOT_MASK, MEM_MASK})
   ) dbus_split (
      .m_req  (dbus_req),
      .m_resp (dbus_resp),
      .s_req  (dbus_s_req),
      .s_resp (dbus_s_resp)
   );

   bus_split #(
      .N_SLAVES    (2),
      .REGION_MASK ({BOOT_MASK, UART_MASK})
   ) pbus_split (
      .m_req  (dbus_s_req[1]),
      .m_resp (dbus_s_resp[1]),
      .s_req  (pbus_s_req),
      .s_resp (pbus_s_resp)
   );

   ////////////////////
   // slaves
   ////////////////////

   // instruction bus goes straight to the fetch port
   int_mem int_mem0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .boot   (boot),
      .i_req  (ibus_req),
      .i_resp (ibus_resp),
      .d_req  (dbus_s_req[0]),
      .d_resp (dbus_s_resp[0])
   );

   boot_ctrl boot_ctrl0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (pbus_s_req[1]),
      .resp      (pbus_s_resp[1]),
      .boot      (boot),
      .cpu_reset (cpu_reset)
   );

   uart_core uart0 (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (pbus_s_req[0]),
      .resp  (pbus_s_resp[0]),
      .txd   (uart_txd),
      .rxd   (uart_rxd),
      .rts   (uart_rts),
      .cts   (uart_cts)
   );

endmodule

`default_nettype wire

//--- source/uart_core.sv
`default_nettype none

`include "system_defs.svh"

module uart_core (
   input  logic                  clk,
   input  logic                  rst_n,
   input  system_pkg::bus_req_t  req,
   output system_pkg::bus_resp_t resp,
   output logic                  txd,
   input  logic                  rxd,
   output logic                  rts,
   input  logic                  cts
);

   import system_pkg::*;

   localparam int BAUD_W = $clog2(`UART_DIV);

   // word offsets
   localparam logic [1:0] REG_STATUS = 2'd0;
   localparam logic [1:0] REG_TX     = 2'd1;
   localparam logic [1:0] REG_RX     = 2'd2;

   bus_addr_u          addr;
   logic [1:0]         reg_sel;
   logic               ready_q;
   logic [`DATA_W-1:0] rdata_q;
   logic               acc_wr;
   logic               acc_rd;

   logic               tx_start;
   logic               tx_busy;
   logic [9:0]         tx_shift;
   logic [3:0]         tx_bits;
   logic [BAUD_W-1:0]  tx_baud;
   logic [7:0]         tx_data;

   logic [1:0]         rx_sync;
   logic               rx_busy;
   logic [3:0]         rx_bits;
   logic [BAUD_W-1:0]  rx_baud;
   logic [7:0]         rx_shift;
   logic [7:0]         rx_data;
   logic               rx_valid;

   assign addr.word = req.addr;
   assign reg_sel   = addr.fields.offset[3:2];
   assign acc_wr    = req.valid & ~ready_q & (|req.wstrb);
   assign acc_rd    = req.valid & ~ready_q & ~(|req.wstrb);
   assign tx_busy   = (tx_bits != 4'd0);
   // writes while busy or while cts is high are dropped
   assign tx_start  = acc_wr && (reg_sel == REG_TX) && !tx_busy && !cts;

   ////////////////////
   // register access
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= req.valid & ~ready_q;
      end
   end

   always_ff @(posedge clk) begin
      if (acc_rd) begin
         case (reg_sel)
            REG_STATUS: rdata_q <= {{(`DATA_W-2){1'b0}}, rx_valid, tx_busy};
            REG_TX:     rdata_q <= {{(`DATA_W-8){1'b0}}, tx_data};
            REG_RX:     rdata_q <= {{(`DATA_W-8){1'b0}}, rx_data};
            default:    rdata_q <= '0;
         endcase
      end
      if (tx_start) begin
         tx_data <= req.wdata[7:0];
      end
   end

   assign resp.rdata = rdata_q;
   assign resp.ready = ready_q;

   ////////////////////
   // transmitter
   ////////////////////

   // frame is start, 8 data lsb first, stop
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_shift <= '1;
         tx_bits  <= 4'd0;
         tx_baud  <= '0;
      end else if (tx_start) begin
         tx_shift <= {1'b1, req.wdata[7:0], 1'b0};
         tx_bits  <= 4'd10;
         tx_baud  <= BAUD_W'(`UART_DIV - 1);
      end else if (tx_busy) begin
         if (tx_baud == '0) begin
            tx_shift <= {1'b1, tx_shift[9:1]};
            tx_bits  <= tx_bits - 4'd1;
            tx_baud  <= BAUD_W'(`UART_DIV - 1);
         end else begin
            tx_baud <= tx_baud - 1'b1;
         end
      end
   end

   assign txd = tx_shift[0];

   ////////////////////
   // receiver
   ////////////////////

   // first sample lands mid start bit, the rest one bit apart
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_sync  <= 2'b11;
         rx_busy  <= 1'b0;
         rx_bits  <= 4'd0;
         rx_baud  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], rxd};
         if (acc_rd && reg_sel == REG_RX) begin
            rx_valid <= 1'b0;
         end
         if (!rx_busy) begin
            if (!rx_sync[1]) begin
               rx_busy <= 1'b1;
               rx_bits <= 4'd10;
               rx_baud <= BAUD_W'(`UART_DIV / 2 - 1);
            end
         end else if (rx_baud != '0) begin
            rx_baud <= rx_baud - 1'b1;
         end else begin
            rx_baud <= BAUD_W'(`UART_DIV - 1);
            rx_bits <= rx_bits - 4'd1;
            if (rx_bits == 4'd10) begin
               // line back high, glitch and not a start bit
               if (rx_sync[1]) begin
                  rx_busy <= 1'b0;
               end
            end else if (rx_bits == 4'd1) begin
               rx_busy <= 1'b0;
               // new byte wins over a clearing read
               if (rx_sync[1]) begin
                  rx_valid <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_busy && rx_baud == '0) begin
         if (rx_bits > 4'd1 && rx_bits < 4'd10) begin
            rx_shift <= {rx_sync[1], rx_shift[7:1]};
         end
         // keep the byte only with a good stop bit
         if (rx_bits == 4'd1 && rx_sync[1]) begin
            rx_data <= rx_shift;
         end
      end
   end

   assign rts = rx_valid;

endmodule

`default_nettype wire

//--- source/boot_ctrl.sv
`default_nettype none

`include "system_defs.svh"

module boot_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  system_pkg::bus_req_t  req,
   output system_pkg::bus_resp_t resp,
   output logic                  boot,
   output logic                  cpu_reset
);

   localparam int CNT_W = $clog2(`BOOT_RESET_CYCLES + 1);

   // reset sequencer states
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_ARM   = 2'd1;
   localparam logic [1:0] ST_PULSE = 2'd2;

   logic [1:0]       state;
   logic [CNT_W-1:0] cnt;
   logic             ready_q;
   logic             wr_en;
   logic             clear_hit;

   assign wr_en     = req.valid & ~ready_q & (|req.wstrb);
   // only a 1 to 0 change of the flag restarts the cpu
   assign clear_hit = wr_en & ~req.wdata[0] & boot;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
         boot    <= 1'b1;
      end else begin
         ready_q <= req.valid & ~ready_q;
         if (clear_hit) begin
            boot <= 1'b0;
         end
      end
   end

   ////////////////////
   // cpu reset pulse
   ////////////////////

   // ARM covers the ready cycle, pulse starts right after it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (clear_hit) begin
                  state <= ST_ARM;
               end
            end
            ST_ARM: begin
               state <= ST_PULSE;
               cnt   <= CNT_W'(`BOOT_RESET_CYCLES - 1);
            end
            ST_PULSE: begin
               if (cnt == '0) begin
                  state <= ST_IDLE;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign cpu_reset  = (state == ST_PULSE);

   assign resp.rdata = {{(`DATA_W-1){1'b0}}, boot};
   assign resp.ready = ready_q;

endmodule

`default_nettype wire

//--- source/int_mem.sv
`default_nettype none

`include "system_defs.svh"

module int_mem (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  boot,
   input  system_pkg::bus_req_t  i_req,
   output system_pkg::bus_resp_t i_resp,
   input  system_pkg::bus_req_t  d_req,
   output system_pkg::bus_resp_t d_resp
);

   import system_pkg::*;

   localparam int WORDS  = 1 << `MEM_ADDR_W;
   localparam int BYTES  = `DATA_W / 8;

   logic [`DATA_W-1:0]    mem [WORDS];

   bus_addr_u             i_addr;
   bus_addr_u             d_addr;
   logic [`MEM_ADDR_W-1:0] i_word;
   logic [`MEM_ADDR_W-1:0] d_word;
   logic                  i_ready;
   logic                  d_ready;
   logic [`DATA_W-1:0]    i_rdata;
   logic [`DATA_W-1:0]    d_rdata;

   assign i_addr.word = i_req.addr;
   assign d_addr.word = d_req.addr;

   // byte address to word index
   assign d_word = d_addr.fields.offset[`MEM_ADDR_W+1:2];

   // boot code lives in the upper half
   assign i_word = boot ? {1'b1, i_addr.fields.offset[`MEM_ADDR_W:2]}
                        : i_addr.fields.offset[`MEM_ADDR_W+1:2];

   ////////////////////
   // handshake
   ////////////////////

   // one ready per accepted valid, each port on its own
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         i_ready <= 1'b0;
         d_ready <= 1'b0;
      end else begin
         i_ready <= i_req.valid & ~i_ready;
         d_ready <= d_req.valid & ~d_ready;
      end
   end

   ////////////////////
   // storage
   ////////////////////

   always_ff @(posedge clk) begin
      if (d_req.valid && !d_ready) begin
         // byte lanes written under strobe
         for (int b = 0; b < BYTES; b++) begin
            if (d_req.wstrb[b]) begin
               mem[d_word][8*b +: 8] <= d_req.wdata[8*b +: 8];
            end
         end
         d_rdata <= mem[d_word];
      end
      // fetch port never writes
      if (i_req.valid && !i_ready) begin
         i_rdata <= mem[i_word];
      end
   end

   assign i_resp.rdata = i_rdata;
   assign i_resp.ready = i_ready;
   assign d_resp.rdata = d_rdata;
   assign d_resp.ready = d_ready;

endmodule

`default_nettype wire

//--- source/bus_split.sv
`default_nettype none

`include "system_defs.svh"

module bus_split #(
   parameter int N_SLAVES = 2,
   // bit r of entry s is set when slave s owns region r
   parameter logic [N_SLAVES-1:0][(1 << `REGION_W)-1:0] REGION_MASK = '0
) (
   input  system_pkg::bus_req_t  m_req,
   output system_pkg::bus_resp_t m_resp,
   output system_pkg::bus_req_t  s_req  [N_SLAVES],
   input  system_pkg::bus_resp_t s_resp [N_SLAVES]
);

   import system_pkg::*;

   localparam int SEL_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   bus_addr_u        addr;
   logic [SEL_W-1:0] sel;

   assign addr.word = m_req.addr;

   ////////////////////
   // region decode
   ////////////////////

   // lowest owning slave wins, unmapped regions fall to slave 0
   always_comb begin
      sel = '0;
      for (int s = N_SLAVES - 1; s >= 0; s--) begin
         if (REGION_MASK[s][addr.fields.region]) begin
            sel = SEL_W'(s);
         end
      end
   end

   ////////////////////
   // request fan-out
   ////////////////////

   // everything broadcast, only the selected slave gets valid
   always_comb begin
      for (int s = 0; s < N_SLAVES; s++) begin
         s_req[s]       = m_req;
         s_req[s].valid = m_req.valid && (sel == SEL_W'(s));
      end
   end

   // response back from the selected slave
   assign m_resp = s_resp[sel];

endmodule

`default_nettype wire

//--- source/system_pkg.sv
`default_nettype none

`include "system_defs.svh"

package system_pkg;

   // master request, held stable until ready
   typedef struct packed {
      logic                 valid;
      logic [`ADDR_W-1:0]   addr;
      logic [`DATA_W-1:0]   wdata;
      logic [`DATA_W/8-1:0] wstrb;
   } bus_req_t;

   // rdata only meaningful while ready is high
   typedef struct packed {
      logic [`DATA_W-1:0] rdata;
      logic               ready;
   } bus_resp_t;

   // region select plus byte offset inside the region
   typedef struct packed {
      logic [`REGION_W-1:0]         region;
      logic [`ADDR_W-`REGION_W-1:0] offset;
   } bus_addr_fields_t;

   // one address word, seen flat or split
   typedef union packed {
      logic [`ADDR_W-1:0] word;
      bus_addr_fields_t   fields;
   } bus_addr_u;

endpackage

`default_nettype wire

//--- include/system_defs.svh
`ifndef SYSTEM_DEFS_SVH
`define SYSTEM_DEFS_SVH

////////////////////
// bus widths
////////////////////

// byte address, 32 bit data words
`define ADDR_W 16
`define DATA_W 32

// internal memory depth, in words
`define MEM_ADDR_W 10

////////////////////
// address regions
////////////////////

// top address bits pick the region
`define REGION_W 2

`define REGION_MEM 0
`define REGION_UART 2
`define REGION_BOOT 3

////////////////////
// timing
////////////////////

// clocks per uart bit
`define UART_DIV 8

// cpu reset pulse after boot clears
`define BOOT_RESET_CYCLES 4

`endif
